//--- list.f
+incdir+rtl
+incdir+verif
rtl/exu_pkg.sv
rtl/alu.sv
rtl/exu.sv
rtl/bpu_table.sv
rtl/pdt_stat_counters.sv
rtl/csr_lite_fsm.sv
rtl/exu_top.sv
verif/tb_exu_top.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module alu (
  input  exu_pkg::xlen_t   alu_a_i,
  input  exu_pkg::xlen_t   alu_b_i,
  input  exu_pkg::alu_op_t alu_op_i,
  output exu_pkg::xlen_t   alu_out_o,
  output logic             compare_out_o
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = alu_b_i[4:0];   // rv32 uses low five bits only
  assign eq    = (alu_a_i == alu_b_i);
  assign lt_s  = ($signed(alu_a_i) < $signed(alu_b_i));
  assign lt_u  = (alu_a_i < alu_b_i);

  always_comb begin
    alu_out_o     = '0;
    compare_out_o = 1'b0;
    case (alu_op_i)
      `ALUOP_ADD:  alu_out_o = alu_a_i + alu_b_i;
      `ALUOP_SUB:  alu_out_o = alu_a_i - alu_b_i;
      `ALUOP_SLL:  alu_out_o = alu_a_i << shamt;
      `ALUOP_SLT:  alu_out_o = {{(`XLEN-1){1'b0}}, lt_s};
      `ALUOP_SLTU: alu_out_o = {{(`XLEN-1){1'b0}}, lt_u};
      `ALUOP_XOR:  alu_out_o = alu_a_i ^ alu_b_i;
      `ALUOP_SRL:  alu_out_o = alu_a_i >> shamt;
      `ALUOP_SRA:  alu_out_o = exu_pkg::xlen_t'($signed(alu_a_i) >>> shamt);
      `ALUOP_OR:   alu_out_o = alu_a_i | alu_b_i;
      `ALUOP_AND:  alu_out_o = alu_a_i & alu_b_i;
      // branch compares, result word stays zero
      `ALUOP_BEQ:  compare_out_o = eq;
      `ALUOP_BNE:  compare_out_o = !eq;
      `ALUOP_BLT:  compare_out_o = lt_s;
      `ALUOP_BGE:  compare_out_o = !lt_s;
      `ALUOP_BLTU: compare_out_o = lt_u;
      `ALUOP_BGEU: compare_out_o = !lt_u;
      default: begin
        alu_out_o     = '0;
        compare_out_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/bpu_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module bpu_table (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  exu_pkg::xlen_t    lookup_pc_i,
  output logic              pdt_res_o,
  input  exu_pkg::bpu_upd_t upd_i
);

  localparam int unsigned ENTRIES = 1 << `BPU_IDX_W;

  logic [1:0]        cnt_q [ENTRIES];
  exu_pkg::bpu_idx_t rd_idx;
  exu_pkg::bpu_idx_t wr_idx;
  logic [1:0]        wr_cnt;

  // word aligned pc, drop the low two bits
  assign rd_idx = lookup_pc_i[`BPU_IDX_W+1:2];
  assign wr_idx = upd_i.pc[`BPU_IDX_W+1:2];

  assign pdt_res_o = cnt_q[rd_idx][1];  // msb = predict taken
  assign wr_cnt    = cnt_q[wr_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;                // weakly not taken
      end
    end else if (upd_i.valid) begin
      if (upd_i.taken && wr_cnt != 2'b11) begin
        cnt_q[wr_idx] <= wr_cnt + 2'b01;
      end else if (!upd_i.taken && wr_cnt != 2'b00) begin
        cnt_q[wr_idx] <= wr_cnt - 2'b01;
      end
    end
  end

  a_upd_pc_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd_i.valid |-> !$isunknown(upd_i.pc));

endmodule

`default_nettype wire

//--- rtl/csr_lite_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module csr_lite_fsm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  exu_pkg::axil_m2s_t axil_i,
  output exu_pkg::axil_s2m_t axil_o,
  input  exu_pkg::xlen_t     branches_i,
  input  exu_pkg::xlen_t     correct_i,
  input  exu_pkg::xlen_t     mispdt_i,
  output logic               clear_o
);

  exu_pkg::csr_state_e state_q;
  logic                rd_take;
  logic                wr_take;
  logic                wr_hit;
  exu_pkg::xlen_t      rd_data;
  logic [1:0]          rd_resp;
  exu_pkg::xlen_t      rdata_q;
  logic [1:0]          rresp_q;
  logic [1:0]          bresp_q;
  logic                clear_q;

  // read wins when both arrive in idle
  assign rd_take = (state_q == exu_pkg::CSR_IDLE) && axil_i.arvalid;
  assign wr_take = (state_q == exu_pkg::CSR_IDLE) && !axil_i.arvalid &&
                   axil_i.awvalid && axil_i.wvalid;
  assign wr_hit  = (axil_i.awaddr == `CSR_CLEAR);

  always_comb begin
    rd_data = '0;
    rd_resp = `AXI_RESP_OKAY;
    case (axil_i.araddr)
      `CSR_BRANCHES: rd_data = branches_i;
      `CSR_CORRECT:  rd_data = correct_i;
      `CSR_MISPDT:   rd_data = mispdt_i;
      default:       rd_resp = `AXI_RESP_SLVERR;  // unmapped, data stays 0
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= exu_pkg::CSR_IDLE;
      clear_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (state_q)
        exu_pkg::CSR_IDLE: begin
          if (rd_take) begin
            state_q <= exu_pkg::CSR_RD_RESP;
          end else if (wr_take) begin
            state_q <= exu_pkg::CSR_WR_RESP;
            clear_q <= wr_hit;
          end
        end
        exu_pkg::CSR_RD_RESP: begin
          if (axil_i.rready) state_q <= exu_pkg::CSR_IDLE;
        end
        exu_pkg::CSR_WR_RESP: begin
          if (axil_i.bready) state_q <= exu_pkg::CSR_IDLE;
        end
        default: state_q <= exu_pkg::CSR_IDLE;
      endcase
    end
  end

  // response payload, held until the handshake
  always_ff @(posedge clk_i) begin
    if (rd_take) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
    if (wr_take) begin
      bresp_q <= wr_hit ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
    end
  end

  assign axil_o.arready = rd_take;
  assign axil_o.awready = wr_take;    // aw and w accepted together
  assign axil_o.wready  = wr_take;
  assign axil_o.rvalid  = (state_q == exu_pkg::CSR_RD_RESP);
  assign axil_o.rdata   = rdata_q;
  assign axil_o.rresp   = rresp_q;
  assign axil_o.bvalid  = (state_q == exu_pkg::CSR_WR_RESP);
  assign axil_o.bresp   = bresp_q;
  assign clear_o        = clear_q;

  a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(axil_o.rvalid && axil_o.bvalid));

endmodule

`default_nettype wire

//--- rtl/exu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module exu (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  exu_pkg::ex_req_t  req_i,
  input  logic              pdt_res_i,     // predicted direction from table
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output exu_pkg::ex_rsp_t  rsp_o,
  output exu_pkg::bpu_upd_t upd_o,
  output logic              pdt_correct_o
);

  logic                 is_jal;
  logic                 is_jalr;
  logic                 is_branch;
  logic                 is_cti;
  logic                 taken;
  logic                 mispdt;
  logic                 cmp_out;
  logic                 in_fire;
  logic                 out_valid_q;
  exu_pkg::xlen_t       imm_upper;
  exu_pkg::xlen_t       alu_a;
  exu_pkg::xlen_t       alu_b;
  exu_pkg::xlen_t       alu_out;
  exu_pkg::xlen_t       redirect_pc;
  exu_pkg::jump_type_t  jump_type;
  exu_pkg::ex_rsp_t     rsp_d;
  exu_pkg::ex_rsp_t     rsp_q;

  assign is_jal    = (req_i.exc_op == `EXCOP_JAL);
  assign is_jalr   = (req_i.exc_op == `EXCOP_JALR);
  assign is_branch = (req_i.exc_op == `EXCOP_BRANCH);
  assign is_cti    = is_jal | is_jalr | is_branch;
  assign imm_upper = {req_i.imm_data[`XLEN-1:12], 12'b0};  // lui / auipc

  // operand select by class
  always_comb begin
    alu_a = req_i.rs1_data;
    alu_b = req_i.rs2_data;
    case (req_i.exc_op)
      `EXCOP_OPREG, `EXCOP_BRANCH, `EXCOP_NONE: begin
        alu_a = req_i.rs1_data;
        alu_b = req_i.rs2_data;
      end
      `EXCOP_OPIMM, `EXCOP_LOAD, `EXCOP_STORE: alu_b = req_i.imm_data;
      `EXCOP_JAL, `EXCOP_JALR: begin    // link address
        alu_a = req_i.pc;
        alu_b = `XLEN'd4;
      end
      `EXCOP_AUIPC: begin
        alu_a = req_i.pc;
        alu_b = imm_upper;
      end
      `EXCOP_LUI: begin
        alu_a = '0;
        alu_b = imm_upper;
      end
      default: ;
    endcase
  end

  alu u_alu (
    .alu_a_i       (alu_a),
    .alu_b_i       (alu_b),
    .alu_op_i      (req_i.alu_op),
    .alu_out_o     (alu_out),
    .compare_out_o (cmp_out)
  );

  assign taken  = is_jal | is_jalr | (is_branch & cmp_out);
  assign mispdt = taken ^ pdt_res_i;

  // wrongly predicted taken falls back to pc+4
  always_comb begin
    if (pdt_res_i && !taken) begin
      redirect_pc = req_i.pc + `XLEN'd4;
    end else if (is_jalr) begin
      redirect_pc = req_i.rs1_data + req_i.imm_data;
    end else begin
      redirect_pc = req_i.pc + req_i.imm_data;
    end
  end

  assign jump_type = is_jal    ? exu_pkg::JT_JAL :
                     is_jalr   ? exu_pkg::JT_JALR :
                     is_branch ? exu_pkg::JT_BRANCH : exu_pkg::JT_NONE;

  always_comb begin
    rsp_d.pc             = req_i.pc;
    rsp_d.rd_idx         = req_i.rd_idx;
    rsp_d.alu_data       = alu_out;
    rsp_d.branch_taken   = taken;
    rsp_d.pdt_correct    = !mispdt;
    rsp_d.jump_type      = jump_type;
    rsp_d.redirect_pc    = redirect_pc;
    rsp_d.redirect_valid = mispdt;
  end

  // single output slot, accept when empty or draining
  assign in_ready_o = !out_valid_q || out_ready_i;
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (in_fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      rsp_q <= rsp_d;
    end
  end

  assign out_valid_o = out_valid_q;
  assign rsp_o       = rsp_q;

  // table and counters train on the accept edge
  assign upd_o.valid   = in_fire && is_cti;
  assign upd_o.pc      = req_i.pc;
  assign upd_o.taken   = taken;
  assign pdt_correct_o = !mispdt;

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o));

endmodule

`default_nettype wire

//--- rtl/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath widths
`define XLEN          32
`define REG_ADDRWIDTH 5

// alu operation codes
`define ALUOP_LEN  4
`define ALUOP_ADD  4'h0
`define ALUOP_SUB  4'h1
`define ALUOP_SLL  4'h2
`define ALUOP_SLT  4'h3
`define ALUOP_SLTU 4'h4
`define ALUOP_XOR  4'h5
`define ALUOP_SRL  4'h6
`define ALUOP_SRA  4'h7
`define ALUOP_OR   4'h8
`define ALUOP_AND  4'h9
`define ALUOP_BEQ  4'ha
`define ALUOP_BNE  4'hb
`define ALUOP_BLT  4'hc
`define ALUOP_BGE  4'hd
`define ALUOP_BLTU 4'he
`define ALUOP_BGEU 4'hf

// operation class, picks the alu operands
`define EXCOP_LEN    4
`define EXCOP_NONE   4'h0
`define EXCOP_LUI    4'h1
`define EXCOP_AUIPC  4'h2
`define EXCOP_JAL    4'h3
`define EXCOP_JALR   4'h4
`define EXCOP_LOAD   4'h5
`define EXCOP_STORE  4'h6
`define EXCOP_BRANCH 4'h7
`define EXCOP_OPIMM  4'h8
`define EXCOP_OPREG  4'h9

`define BPU_IDX_W 6   // 64 entries
`define STAT_W    32

// register block offsets
`define CSR_BRANCHES 32'h0000_0000
`define CSR_CORRECT  32'h0000_0004
`define CSR_MISPDT   32'h0000_0008
`define CSR_CLEAR    32'h0000_000c

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- rtl/exu_pkg.sv
`default_nettype none
`include "exu_consts.svh"

package exu_pkg;

  typedef logic [`XLEN-1:0]          xlen_t;
  typedef logic [`REG_ADDRWIDTH-1:0] reg_idx_t;
  typedef logic [`ALUOP_LEN-1:0]     alu_op_t;
  typedef logic [`EXCOP_LEN-1:0]     exc_op_t;
  typedef logic [`BPU_IDX_W-1:0]     bpu_idx_t;
  typedef logic [1:0]                jump_type_t;

  localparam jump_type_t JT_NONE   = 2'd0;
  localparam jump_type_t JT_JAL    = 2'd1;
  localparam jump_type_t JT_JALR   = 2'd2;
  localparam jump_type_t JT_BRANCH = 2'd3;

  // decoded instruction into the stage
  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rd_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm_data;
    alu_op_t  alu_op;
    exc_op_t  exc_op;
  } ex_req_t;

  typedef struct packed {
    xlen_t      pc;
    reg_idx_t   rd_idx;
    xlen_t      alu_data;
    logic       branch_taken;   // actual direction
    logic       pdt_correct;
    jump_type_t jump_type;
    xlen_t      redirect_pc;
    logic       redirect_valid; // flush and refetch
  } ex_rsp_t;

  // resolved branch, trains table and counters
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    logic  taken;
  } bpu_upd_t;

  typedef struct packed {
    xlen_t awaddr;
    logic  awvalid;
    xlen_t wdata;
    logic  wvalid;
    logic  bready;
    xlen_t araddr;
    logic  arvalid;
    logic  rready;
  } axil_m2s_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    xlen_t      rdata;
    logic [1:0] rresp;
  } axil_s2m_t;

  typedef enum logic [1:0] {
    CSR_IDLE,
    CSR_RD_RESP,
    CSR_WR_RESP
  } csr_state_e;

endpackage

`default_nettype wire

//--- rtl/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  exu_pkg::ex_req_t   req_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output exu_pkg::ex_rsp_t   rsp_o,
  input  exu_pkg::axil_m2s_t axil_i,
  output exu_pkg::axil_s2m_t axil_o
);

  logic              pdt_res;
  logic              pdt_correct;
  logic              stat_clear;
  exu_pkg::bpu_upd_t bpu_upd;
  exu_pkg::xlen_t    cnt_branches;
  exu_pkg::xlen_t    cnt_correct;
  exu_pkg::xlen_t    cnt_mispdt;

  exu u_exu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .req_i         (req_i),
    .pdt_res_i     (pdt_res),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .rsp_o         (rsp_o),
    .upd_o         (bpu_upd),
    .pdt_correct_o (pdt_correct)
  );

  // lookup on the incoming request pc
  bpu_table u_bpu_table (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (req_i.pc),
    .pdt_res_o   (pdt_res),
    .upd_i       (bpu_upd)
  );

  pdt_stat_counters u_pdt_stat_counters (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .upd_i      (bpu_upd),
    .correct_i  (pdt_correct),
    .clear_i    (stat_clear),
    .branches_o (cnt_branches),
    .correct_o  (cnt_correct),
    .mispdt_o   (cnt_mispdt)
  );

  csr_lite_fsm u_csr_lite_fsm (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_i     (axil_i),
    .axil_o     (axil_o),
    .branches_i (cnt_branches),
    .correct_i  (cnt_correct),
    .mispdt_i   (cnt_mispdt),
    .clear_o    (stat_clear)
  );

endmodule

`default_nettype wire

//--- rtl/pdt_stat_counters.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module pdt_stat_counters (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  exu_pkg::bpu_upd_t upd_i,
  input  logic              correct_i,
  input  logic              clear_i,     // one cycle pulse from csr block
  output exu_pkg::xlen_t    branches_o,
  output exu_pkg::xlen_t    correct_o,
  output exu_pkg::xlen_t    mispdt_o
);

  logic [`STAT_W-1:0] branches_q;
  logic [`STAT_W-1:0] correct_q;
  logic [`STAT_W-1:0] mispdt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin    // clear beats a same cycle update
      branches_q <= '0;
      correct_q  <= '0;
      mispdt_q   <= '0;
    end else if (upd_i.valid) begin
      branches_q <= branches_q + 1'b1;
      if (correct_i) begin
        correct_q <= correct_q + 1'b1;
      end else begin
        mispdt_q <= mispdt_q + 1'b1;
      end
    end
  end

  // counts wrap, no saturation
  assign branches_o = branches_q;
  assign correct_o  = correct_q;
  assign mispdt_o   = mispdt_q;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_exu_top -f list.f \
  && ./obj_dir/Vtb_exu_top > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/exu_ref_model.svh
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// predictor and counter state, kept in step with the dut
logic [1:0]     ref_cnt [1 << `BPU_IDX_W];
exu_pkg::xlen_t ref_branches;
exu_pkg::xlen_t ref_correct;
exu_pkg::xlen_t ref_mispdt;

function automatic exu_pkg::xlen_t ref_alu(input exu_pkg::xlen_t a, input exu_pkg::xlen_t b,
                                           input exu_pkg::alu_op_t op);
  logic [2*`XLEN-1:0] ext;
  ext = {{`XLEN{a[`XLEN-1]}}, a} >> b[4:0];   // sign filled shift
  case (op)
    `ALUOP_ADD:  return a + b;
    `ALUOP_SUB:  return a + ~b + 32'd1;
    `ALUOP_SLL:  return a << b[4:0];
    `ALUOP_SLT:  return (a[31] != b[31]) ? exu_pkg::xlen_t'(a[31]) : exu_pkg::xlen_t'(a < b);
    `ALUOP_SLTU: return exu_pkg::xlen_t'(a < b);
    `ALUOP_XOR:  return a ^ b;
    `ALUOP_SRL:  return a >> b[4:0];
    `ALUOP_SRA:  return ext[`XLEN-1:0];
    `ALUOP_OR:   return a | b;
    `ALUOP_AND:  return a & b;
    default:     return '0;   // compares give no word
  endcase
endfunction

function automatic logic ref_cond(input exu_pkg::ex_req_t q);
  logic lt_u;
  logic lt_s;
  lt_u = q.rs1_data < q.rs2_data;
  lt_s = (q.rs1_data[31] != q.rs2_data[31]) ? q.rs1_data[31] : lt_u;
  case (q.alu_op)
    `ALUOP_BEQ:  return q.rs1_data == q.rs2_data;
    `ALUOP_BNE:  return q.rs1_data != q.rs2_data;
    `ALUOP_BLT:  return lt_s;
    `ALUOP_BGE:  return !lt_s;
    `ALUOP_BLTU: return lt_u;
    `ALUOP_BGEU: return !lt_u;
    default:     return 1'b0;
  endcase
endfunction

function automatic exu_pkg::ex_rsp_t ref_expect(input exu_pkg::ex_req_t q);
  exu_pkg::xlen_t   a;
  exu_pkg::xlen_t   b;
  exu_pkg::xlen_t   upper;
  logic             pdt;
  logic             taken;
  exu_pkg::ex_rsp_t e;
  upper = q.imm_data & 32'hffff_f000;
  a     = q.rs1_data;
  b     = q.rs2_data;
  case (q.exc_op)
    `EXCOP_LUI: begin
      a = '0;
      b = upper;
    end
    `EXCOP_AUIPC: begin
      a = q.pc;
      b = upper;
    end
    `EXCOP_JAL, `EXCOP_JALR: begin
      a = q.pc;
      b = 32'd4;
    end
    `EXCOP_LOAD, `EXCOP_STORE, `EXCOP_OPIMM: b = q.imm_data;
    default: ;
  endcase
  pdt   = ref_cnt[q.pc[`BPU_IDX_W+1:2]][1];
  taken = (q.exc_op == `EXCOP_JAL) || (q.exc_op == `EXCOP_JALR) ||
          ((q.exc_op == `EXCOP_BRANCH) && ref_cond(q));
  e.pc             = q.pc;
  e.rd_idx         = q.rd_idx;
  e.alu_data       = ref_alu(a, b, q.alu_op);
  e.branch_taken   = taken;
  e.pdt_correct    = (taken == pdt);
  e.redirect_valid = (taken != pdt);
  case (q.exc_op)
    `EXCOP_JAL:    e.jump_type = exu_pkg::JT_JAL;
    `EXCOP_JALR:   e.jump_type = exu_pkg::JT_JALR;
    `EXCOP_BRANCH: e.jump_type = exu_pkg::JT_BRANCH;
    default:       e.jump_type = exu_pkg::JT_NONE;
  endcase
  if (pdt && !taken) e.redirect_pc = q.pc + 32'd4;
  else if (q.exc_op == `EXCOP_JALR) e.redirect_pc = q.rs1_data + q.imm_data;
  else e.redirect_pc = q.pc + q.imm_data;
  return e;
endfunction

// saturating 2-bit counter rule, plus the statistics
task automatic ref_train(input exu_pkg::ex_req_t q, input exu_pkg::ex_rsp_t e);
  exu_pkg::bpu_idx_t i;
  i = q.pc[`BPU_IDX_W+1:2];
  if (e.jump_type != exu_pkg::JT_NONE) begin
    if (e.branch_taken && ref_cnt[i] != 2'd3) ref_cnt[i] = ref_cnt[i] + 2'd1;
    if (!e.branch_taken && ref_cnt[i] != 2'd0) ref_cnt[i] = ref_cnt[i] - 2'd1;
    ref_branches = ref_branches + 32'd1;
    if (e.pdt_correct) ref_correct = ref_correct + 32'd1;
    else ref_mispdt = ref_mispdt + 32'd1;
  end
endtask

task automatic ref_clear();
  ref_branches = '0;
  ref_correct  = '0;
  ref_mispdt   = '0;
endtask

task automatic ref_reset();
  for (int i = 0; i < (1 << `BPU_IDX_W); i++) begin
    ref_cnt[i] = 2'b01;   // weakly not taken
  end
  ref_clear();
endtask

`endif

//--- verif/tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "exu_consts.svh"

module tb_exu_top;

  localparam int CLK_PERIOD  = 20;
  localparam int N_INSTR     = 828;   // all streams together
  localparam int N_REGACC    = 13;
  localparam int WDOG_CYCLES = N_INSTR * 4 + N_REGACC * 10 + 100;

  logic               clk_i;
  logic               rst_n_i;
  logic               in_valid_i;
  logic               in_ready_o;
  exu_pkg::ex_req_t   req_i;
  logic               out_valid_o;
  logic               out_ready_i;
  exu_pkg::ex_rsp_t   rsp_o;
  exu_pkg::axil_m2s_t axil_m;
  exu_pkg::axil_s2m_t axil_s;

  logic [15:0]        lfsr_state;
  exu_pkg::ex_rsp_t   exp_q [$];   // responses still owed by the dut
  int                 check_count;
  int                 err_count;
  int                 test_count;

  `include "exu_ref_model.svh"

  exu_top u_exu_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .req_i       (req_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_o       (rsp_o),
    .axil_i      (axil_m),
    .axil_o      (axil_s)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic lfsr_step();
    logic out;
    out        = lfsr_state[15];
    lfsr_state = {lfsr_state[14:0],
                  lfsr_state[15] ^ lfsr_state[14] ^ lfsr_state[12] ^ lfsr_state[3]};
    return out;
  endfunction

  function automatic exu_pkg::xlen_t rand_bits(input int n);
    exu_pkg::xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic exu_pkg::exc_op_t plain_class(input int sel);
    case (sel)
      0:       return `EXCOP_LUI;
      1:       return `EXCOP_AUIPC;
      2:       return `EXCOP_LOAD;
      3:       return `EXCOP_STORE;
      4:       return `EXCOP_OPIMM;
      default: return `EXCOP_OPREG;
    endcase
  endfunction

  // mode 0 alu only, 1 mostly branches, 2 one taken branch, 3 anything
  function automatic exu_pkg::ex_req_t gen_req(input int mode);
    exu_pkg::ex_req_t r;
    exu_pkg::xlen_t   imm12;
    int               sel;
    r.pc       = 32'h0000_0100 + (rand_bits(4) << 2);  // few pcs so entries get reused
    r.rd_idx   = exu_pkg::reg_idx_t'(rand_bits(5));
    r.rs1_data = rand_bits(1) ? rand_bits(3) : rand_bits(32);
    r.rs2_data = rand_bits(1) ? rand_bits(3) : rand_bits(32);
    imm12      = rand_bits(12);
    r.imm_data = {{20{imm12[11]}}, imm12[11:0]};
    r.alu_op   = `ALUOP_ADD;
    sel        = int'(rand_bits(2));
    case (mode)
      0: r.exc_op = plain_class(int'(rand_bits(3) % 6));
      2: begin
        r.pc       = 32'h0000_0040;
        r.exc_op   = `EXCOP_BRANCH;
        r.alu_op   = `ALUOP_BEQ;
        r.rs2_data = r.rs1_data;
      end
      default: begin
        if (sel < 2 - (mode == 3)) r.exc_op = `EXCOP_BRANCH;
        else if (sel == 2 - (mode == 3)) r.exc_op = rand_bits(1) ? `EXCOP_JALR : `EXCOP_JAL;
        else r.exc_op = plain_class(int'(rand_bits(3) % 6));
      end
    endcase
    if (r.exc_op == `EXCOP_OPREG || r.exc_op == `EXCOP_OPIMM) begin
      r.alu_op = exu_pkg::alu_op_t'(rand_bits(4) % 10);
    end else if (r.exc_op == `EXCOP_BRANCH && mode != 2) begin
      r.alu_op = exu_pkg::alu_op_t'(10 + rand_bits(3) % 6);
      if (rand_bits(1)) r.rs2_data = r.rs1_data;   // more taken compares
    end
    return r;
  endfunction

  task automatic check_rsp(input string name, input exu_pkg::ex_rsp_t exp,
                           input exu_pkg::ex_rsp_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input exu_pkg::xlen_t exp,
                            input exu_pkg::xlen_t act, input logic [1:0] exp_resp,
                            input logic [1:0] act_resp);
    check_count++;
    if (act !== exp || act_resp !== exp_resp) begin
      err_count++;
      $display("Fail %s: expected %h resp %b actual %h resp %b",
               name, exp, exp_resp, act, act_resp);
    end
  endtask

  task automatic finish_test(input string name, input int e0, input int c0);
    test_count++;
    $display("%s: %0d checks, %0d errors", name, check_count - c0, err_count - e0);
  endtask

  task automatic axil_read(input exu_pkg::xlen_t addr, output exu_pkg::xlen_t data,
                           output logic [1:0] resp);
    @(posedge clk_i);
    axil_m.araddr  <= addr;
    axil_m.arvalid <= 1'b1;
    axil_m.rready  <= 1'b1;
    @(negedge clk_i);
    while (!axil_s.arready) @(negedge clk_i);
    @(posedge clk_i);
    axil_m.arvalid <= 1'b0;
    @(negedge clk_i);
    while (!axil_s.rvalid) @(negedge clk_i);
    data = axil_s.rdata;
    resp = axil_s.rresp;
    @(posedge clk_i);
    axil_m.rready <= 1'b0;
  endtask

  task automatic axil_write(input exu_pkg::xlen_t addr, input exu_pkg::xlen_t data,
                            output logic [1:0] resp);
    @(posedge clk_i);
    axil_m.awaddr  <= addr;
    axil_m.awvalid <= 1'b1;
    axil_m.wdata   <= data;
    axil_m.wvalid  <= 1'b1;
    axil_m.bready  <= 1'b1;
    @(negedge clk_i);
    while (!axil_s.awready) @(negedge clk_i);
    if (!axil_s.wready) begin   // aw and w go in the same cycle
      err_count++;
      $display("write data was not taken together with the write address");
    end
    @(posedge clk_i);
    axil_m.awvalid <= 1'b0;
    axil_m.wvalid  <= 1'b0;
    @(negedge clk_i);
    while (!axil_s.bvalid) @(negedge clk_i);
    resp = axil_s.bresp;
    @(posedge clk_i);
    axil_m.bready <= 1'b0;
  endtask

  // drive on rising edge, observe both handshakes on the falling edge
  task automatic run_stream(input string name, input int mode, input int count);
    exu_pkg::ex_req_t nxt;
    exu_pkg::ex_rsp_t held;
    exu_pkg::ex_rsp_t exp;
    logic             pending;
    logic             offered;
    logic             stalled;
    int               issued;
    int               received;
    int               e0;
    int               c0;
    e0       = err_count;
    c0       = check_count;
    nxt      = '0;
    held     = '0;
    pending  = 1'b0;
    offered  = 1'b0;
    stalled  = 1'b0;
    issued   = 0;
    received = 0;
    while (received < count) begin
      @(posedge clk_i);
      if (!pending && issued < count) begin
        nxt     = gen_req(mode);
        pending = 1'b1;
        issued++;
      end
      if (pending && !offered) offered = (rand_bits(2) != 0);  // valid stays up once raised
      in_valid_i  <= offered;
      req_i       <= nxt;
      out_ready_i <= (mode == 3) ? (rand_bits(1) != 0) : (rand_bits(2) != 0);
      @(negedge clk_i);
      if (stalled) begin
        if (!out_valid_o) begin
          err_count++;
          $display("%s: response vanished while the output was stalled", name);
        end
        check_rsp({name, " hold"}, held, rsp_o);
      end
      stalled = out_valid_o && !out_ready_i;
      held    = rsp_o;
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("%s: response arrived with no instruction outstanding", name);
        end else begin
          exp = exp_q.pop_front();
          check_rsp(name, exp, rsp_o);
        end
        received++;
      end
      if (in_valid_i && in_ready_o) begin
        exp = ref_expect(req_i);
        ref_train(req_i, exp);
        exp_q.push_back(exp);
        pending = 1'b0;
        offered = 1'b0;
      end
    end
    @(posedge clk_i);
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    if (out_valid_o || exp_q.size() != 0) begin
      err_count++;
      $display("%s: stream ended with a response missing or duplicated", name);
      exp_q.delete();
    end
    finish_test(name, e0, c0);
  endtask

  task automatic test_counter_regs(input string name);
    exu_pkg::xlen_t d;
    logic [1:0]     r;
    int             e0;
    int             c0;
    e0 = err_count;
    c0 = check_count;
    axil_read(`CSR_BRANCHES, d, r);
    check_word({name, " branches"}, ref_branches, d, `AXI_RESP_OKAY, r);
    axil_read(`CSR_CORRECT, d, r);
    check_word({name, " correct"}, ref_correct, d, `AXI_RESP_OKAY, r);
    axil_read(`CSR_MISPDT, d, r);
    check_word({name, " mispredicted"}, ref_mispdt, d, `AXI_RESP_OKAY, r);
    axil_read(32'h0000_0010, d, r);
    check_word({name, " unmapped read"}, 32'h0, d, `AXI_RESP_SLVERR, r);
    finish_test(name, e0, c0);
  endtask

  task automatic test_clear();
    exu_pkg::xlen_t d;
    logic [1:0]     r;
    int             e0;
    int             c0;
    e0 = err_count;
    c0 = check_count;
    axil_write(`CSR_CLEAR, 32'h1, r);
    check_word("clear write", 32'h0, 32'h0, `AXI_RESP_OKAY, r);
    ref_clear();
    axil_read(`CSR_BRANCHES, d, r);
    check_word("cleared branches", 32'h0, d, `AXI_RESP_OKAY, r);
    axil_read(`CSR_CORRECT, d, r);
    check_word("cleared correct", 32'h0, d, `AXI_RESP_OKAY, r);
    axil_read(`CSR_MISPDT, d, r);
    check_word("cleared mispredicted", 32'h0, d, `AXI_RESP_OKAY, r);
    axil_write(32'h0000_0020, 32'h1, r);
    check_word("unmapped write", 32'h0, 32'h0, `AXI_RESP_SLVERR, r);
    finish_test("counter clear", e0, c0);
  endtask

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    req_i       = '0;
    axil_m      = '0;
    lfsr_state  = 16'd77;
    check_count = 0;
    err_count   = 0;
    test_count  = 0;
    ref_reset();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    run_stream("predictor training", 2, 8);   // entry still at reset value here
    run_stream("alu operands", 0, 300);
    run_stream("branch redirect", 1, 300);
    run_stream("back-pressure", 3, 200);
    test_counter_regs("counter registers");
    test_clear();
    run_stream("branches after clear", 1, 20);
    test_counter_regs("counters after clear");
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
